//--- list.f
verilog/aq_cfg_pkg.sv
verilog/aq_req_pkg.sv
verilog/aq_if.sv
verilog/access_queue.sv
verilog/aq_selector.sv
verilog/cache_aq_sys.sv
testbench/cache_aq_sys_assert.sv
testbench/tb_cache_aq_sys.sv

//--- run.sh
#!/bin/sh
# Build and run the cache access-queue testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_aq_sys \
    -f list.f \
    -o sim_tb

# keep going after an assertion error so the testbench can report it
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- testbench/tb_cache_aq_sys.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cache_aq_sys;

    import aq_cfg_pkg::*;
    import aq_req_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    // summed over all tests, drains included
    localparam int TEST_CYCLES  = 330;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 100) * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst_n;
    logic rd_write;
    logic sw_write;
    logic wb_write;
    logic rdsw_clr;
    logic wb_clr;
    logic read;
    logic bus_isempty;

    // stimulus kept in output form, so it doubles as the expected value
    aq_out_t rd_req;
    aq_out_t sw_req;
    aq_out_t wb_req;
    aq_out_t bus_req;
    aq_out_t dut_out;

    logic from_bus;
    logic w_flag;
    logic r_flag;
    logic sw_flag;
    logic aq_isempty;
    logic rd_full;
    logic sw_full;
    logic wb_full;

    // golden queues
    aq_out_t rd_q[$];
    aq_out_t sw_q[$];
    aq_out_t wb_q[$];

    logic [31:0] lfsr = 32'd93;
    int err_cnt = 0;
    int check_cnt = 0;
    int test_cnt = 0;
    int test_fail_cnt = 0;
    int pop_cnt = 0;
    int total_errs;

    cache_aq_sys UUT (
        .clk (clk), .rst_n_i (rst_n),
        .rd_write_i (rd_write), .sw_write_i (sw_write), .wb_write_i (wb_write),
        .rdsw_clr_i (rdsw_clr), .wb_clr_i (wb_clr),
        .read_i (read), .bus_isempty_i (bus_isempty),
        .rd_valid_e_i (rd_req.valid_e), .rd_valid_o_i (rd_req.valid_o),
        .rd_paddr_e_i (rd_req.paddr_e), .rd_paddr_o_i (rd_req.paddr_o),
        .rd_size_e_i (rd_req.size_e), .rd_size_o_i (rd_req.size_o),
        .rd_ptcid_i (rd_req.ptcid), .rd_qslot_i (rd_req.qslot), .rd_pcd_i (rd_req.pcd),
        .sw_valid_e_i (sw_req.valid_e), .sw_valid_o_i (sw_req.valid_o),
        .sw_paddr_e_i (sw_req.paddr_e), .sw_paddr_o_i (sw_req.paddr_o),
        .sw_size_e_i (sw_req.size_e), .sw_size_o_i (sw_req.size_o),
        .sw_ptcid_i (sw_req.ptcid), .sw_qslot_i (sw_req.qslot), .sw_pcd_i (sw_req.pcd),
        .wb_valid_e_i (wb_req.valid_e), .wb_valid_o_i (wb_req.valid_o),
        .wb_paddr_e_i (wb_req.paddr_e), .wb_paddr_o_i (wb_req.paddr_o),
        .wb_data_e_i (wb_req.data_e), .wb_data_o_i (wb_req.data_o),
        .wb_mask_e_i (wb_req.mask_e), .wb_mask_o_i (wb_req.mask_o),
        .wb_size_e_i (wb_req.size_e), .wb_size_o_i (wb_req.size_o),
        .wb_ptcid_i (wb_req.ptcid), .wb_pcd_i (wb_req.pcd),
        .bus_valid_e_i (bus_req.valid_e), .bus_valid_o_i (bus_req.valid_o),
        .bus_paddr_e_i (bus_req.paddr_e), .bus_paddr_o_i (bus_req.paddr_o),
        .bus_data_e_i (bus_req.data_e), .bus_data_o_i (bus_req.data_o),
        .bus_pcd_i (bus_req.pcd),
        .valid_e_o (dut_out.valid_e), .valid_o_o (dut_out.valid_o),
        .paddr_e_o (dut_out.paddr_e), .paddr_o_o (dut_out.paddr_o),
        .data_e_o (dut_out.data_e), .data_o_o (dut_out.data_o),
        .mask_e_o (dut_out.mask_e), .mask_o_o (dut_out.mask_o),
        .size_e_o (dut_out.size_e), .size_o_o (dut_out.size_o),
        .ptcid_o (dut_out.ptcid), .qslot_o (dut_out.qslot), .pcd_o (dut_out.pcd),
        .from_bus_o (from_bus), .w_o (w_flag), .sw_o (sw_flag), .r_o (r_flag),
        .aq_isempty_o (aq_isempty),
        .rdaq_isfull_o (rd_full), .swaq_isfull_o (sw_full), .wbaq_isfull_o (wb_full)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois form of x^32 + x^31 + x^29 + x + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'hD000_0001;
        end
        return b;
    endfunction

    function automatic logic [LINE_W-1:0] take_bits(input int n);
        logic [LINE_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[LINE_W-2:0], lfsr_bit()};
        end
        return v;
    endfunction

    // fields a source does not carry stay as the consumer must see them
    function automatic aq_out_t rand_req(input aq_src_e src);
        aq_out_t r;
        r = '0;
        r.valid_e = 1'(take_bits(1));
        r.valid_o = 1'(take_bits(1));
        r.paddr_e = PADDR_W'(take_bits(PADDR_W));
        r.paddr_o = PADDR_W'(take_bits(PADDR_W));
        r.pcd     = 1'(take_bits(1));
        if (src == SRC_BUS) begin
            r.data_e = take_bits(LINE_W);
            r.data_o = take_bits(LINE_W);
            r.mask_e = '1;
            r.mask_o = '1;
        end else begin
            r.size_e = SIZE_W'(take_bits(SIZE_W));
            r.size_o = SIZE_W'(take_bits(SIZE_W));
            r.ptcid  = PTCID_W'(take_bits(PTCID_W));
            if (src == SRC_WB) begin
                r.data_e = take_bits(LINE_W);
                r.data_o = take_bits(LINE_W);
                r.mask_e = MASK_W'(take_bits(MASK_W));
                r.mask_o = MASK_W'(take_bits(MASK_W));
            end else begin
                r.qslot = QSLOT_W'(take_bits(QSLOT_W));
            end
        end
        return r;
    endfunction

    function automatic aq_src_e expected_source();
        if (!bus_isempty) begin
            return SRC_BUS;
        end else if (wb_q.size() != 0) begin
            return SRC_WB;
        end else if (rd_q.size() != 0) begin
            return SRC_RD;
        end else if (sw_q.size() != 0) begin
            return SRC_SW;
        end
        return SRC_NONE;
    endfunction

    task automatic check(input string name, input logic [511:0] expected,
                         input logic [511:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic advance_queue(ref aq_out_t q[$], input logic clr, input logic pop,
                                 input logic wr, input aq_out_t din);
        logic was_full;
        was_full = (q.size() == AQ_DEPTH);
        if (clr) begin
            q.delete();
        end else begin
            if (pop) begin
                void'(q.pop_front());
            end
            if (wr && (!was_full || pop)) begin
                q.push_back(din);
            end
        end
    endtask

    // inputs are already set for this cycle, we stand on a falling edge
    task automatic step_cycle(input string name);
        aq_out_t exp_out;
        aq_src_e src;
        logic [3:0] exp_flags;
        logic [2:0] exp_full;
        #1;
        src = expected_source();
        case (src)
            SRC_BUS: exp_out = bus_req;
            SRC_WB:  exp_out = wb_q[0];
            SRC_RD:  exp_out = rd_q[0];
            SRC_SW:  exp_out = sw_q[0];
            default: exp_out = '0;
        endcase
        exp_flags = {src == SRC_BUS, src == SRC_WB, src == SRC_RD, src == SRC_SW};
        exp_full = {rd_q.size() == AQ_DEPTH, sw_q.size() == AQ_DEPTH, wb_q.size() == AQ_DEPTH};
        check({name, " output"}, exp_out, dut_out);
        check({name, " flags"}, exp_flags, {from_bus, w_flag, r_flag, sw_flag});
        check({name, " full"}, exp_full, {rd_full, sw_full, wb_full});
        check({name, " empty"}, src == SRC_NONE, aq_isempty);
        // queue pops as the DUT reports them
        if (read && (w_flag || r_flag || sw_flag)) begin
            pop_cnt++;
        end
        advance_queue(rd_q, rdsw_clr, read && src == SRC_RD, rd_write, rd_req);
        advance_queue(sw_q, rdsw_clr, read && src == SRC_SW, sw_write, sw_req);
        advance_queue(wb_q, wb_clr, read && src == SRC_WB, wb_write, wb_req);
        @(negedge clk);
        rd_write = 1'b0;
        sw_write = 1'b0;
        wb_write = 1'b0;
        rdsw_clr = 1'b0;
        wb_clr = 1'b0;
        read = 1'b0;
    endtask

    task automatic load_request(input aq_src_e src);
        case (src)
            SRC_RD: begin
                rd_req = rand_req(SRC_RD);
                rd_write = 1'b1;
            end
            SRC_SW: begin
                sw_req = rand_req(SRC_SW);
                sw_write = 1'b1;
            end
            SRC_WB: begin
                wb_req = rand_req(SRC_WB);
                wb_write = 1'b1;
            end
            default: begin
                bus_req = rand_req(SRC_BUS);
                bus_isempty = 1'b0;
            end
        endcase
    endtask

    task automatic fill_all(input string name, input int n);
        for (int i = 0; i < n; i++) begin
            load_request(SRC_RD);
            load_request(SRC_SW);
            load_request(SRC_WB);
            step_cycle(name);
        end
    endtask

    task automatic drain_all(input string name);
        int guard;
        guard = 0;
        bus_isempty = 1'b1;
        while ((rd_q.size() + sw_q.size() + wb_q.size()) != 0 && guard < 3 * AQ_DEPTH) begin
            read = 1'b1;
            step_cycle(name);
            guard++;
        end
        step_cycle(name);
    endtask

    task automatic finish_test(input string name, input int start);
        test_cnt++;
        if (err_cnt == start) begin
            $display("test %s ok", name);
        end else begin
            test_fail_cnt++;
            $display("test %s failed with %0d errors", name, err_cnt - start);
        end
    endtask

    task automatic check_reset_state();
        int start;
        start = err_cnt;
        step_cycle("reset_state");
        finish_test("reset_state", start);
    endtask

    task automatic fifo_order();
        int start;
        start = err_cnt;
        for (int i = 0; i < 5; i++) begin
            load_request(SRC_RD);
            step_cycle("fifo_order rd");
        end
        drain_all("fifo_order rd");
        for (int i = 0; i < 5; i++) begin
            load_request(SRC_SW);
            step_cycle("fifo_order sw");
        end
        drain_all("fifo_order sw");
        for (int i = 0; i < 5; i++) begin
            load_request(SRC_WB);
            step_cycle("fifo_order wb");
        end
        drain_all("fifo_order wb");
        finish_test("fifo_order", start);
    endtask

    task automatic priority_order();
        int start;
        start = err_cnt;
        fill_all("priority", 3);
        // bus wins and a read must not touch the queues
        load_request(SRC_BUS);
        for (int i = 0; i < 2; i++) begin
            read = 1'b1;
            step_cycle("priority bus");
        end
        drain_all("priority drain");
        finish_test("priority", start);
    endtask

    task automatic full_and_drop();
        int start;
        int pops_before;
        start = err_cnt;
        for (int i = 0; i < AQ_DEPTH + 1; i++) begin
            load_request(SRC_RD);
            step_cycle("full_drop");
        end
        check("full_drop flag", 1'b1, rd_full);
        pops_before = pop_cnt;
        drain_all("full_drop");
        check("full_drop count", AQ_DEPTH, pop_cnt - pops_before);
        finish_test("full_drop", start);
    endtask

    task automatic clear_queues();
        int start;
        start = err_cnt;
        fill_all("clear", 3);
        rdsw_clr = 1'b1;
        step_cycle("clear rdsw");
        step_cycle("clear rdsw");
        wb_clr = 1'b1;
        step_cycle("clear wb");
        check("clear empty", 1'b1, aq_isempty);
        finish_test("clear", start);
    endtask

    task automatic random_mix();
        int start;
        start = err_cnt;
        for (int i = 0; i < 200; i++) begin
            if (2'(take_bits(2)) == 2'd0) begin
                load_request(SRC_RD);
            end
            if (2'(take_bits(2)) == 2'd0) begin
                load_request(SRC_SW);
            end
            if (2'(take_bits(2)) == 2'd0) begin
                load_request(SRC_WB);
            end
            bus_isempty = 1'b1;
            if (3'(take_bits(3)) == 3'd0) begin
                load_request(SRC_BUS);
            end
            read = (2'(take_bits(2)) != 2'd0);
            step_cycle("random_mix");
        end
        drain_all("random_mix drain");
        finish_test("random_mix", start);
    endtask

    initial begin
        rst_n = 1'b0;
        rd_write = 1'b0;
        sw_write = 1'b0;
        wb_write = 1'b0;
        rdsw_clr = 1'b0;
        wb_clr = 1'b0;
        read = 1'b0;
        bus_isempty = 1'b1;
        rd_req = '0;
        sw_req = '0;
        wb_req = '0;
        bus_req = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        fifo_order();
        priority_order();
        full_and_drop();
        clear_queues();
        random_mix();

        total_errs = err_cnt + UUT.u_chk.n_fail;
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt, UUT.u_chk.n_fail);
        if (total_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cache_aq_sys_assert.sv
`default_nettype none
`timescale 1ns/1ps

module cache_aq_sys_assert (
    input wire logic       clk_i,
    input wire logic       rst_n_i,
    // bit order wb, sw, rd
    input wire logic [2:0] full_i,
    input wire logic [2:0] empty_i,
    input wire logic [2:0] pop_i,
    // bit order bus, wb, rd, sw
    input wire logic [3:0] flags_i,
    input wire logic       aq_isempty_i
);

    int n_full_empty = 0;
    int n_pop_empty  = 0;
    int n_onehot     = 0;
    int n_idle_flag  = 0;
    int n_fail;

    assign n_fail = n_full_empty + n_pop_empty + n_onehot + n_idle_flag;

    a_full_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (full_i & empty_i) == 3'b000)
        else begin
            $error("queue reports full and empty together");
            n_full_empty++;
        end

    a_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pop_i & empty_i) == 3'b000)
        else begin
            $error("pop of an empty queue");
            n_pop_empty++;
        end

    a_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(flags_i))
        else begin
            $error("more than one source flag set");
            n_onehot++;
        end

    // nothing pending means nothing selected
    a_idle_flag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        aq_isempty_i |-> (flags_i == 4'b0000))
        else begin
            $error("source flag set while all sources are empty");
            n_idle_flag++;
        end

endmodule

bind cache_aq_sys cache_aq_sys_assert u_chk (
    .clk_i        (clk),
    .rst_n_i      (rst_n_i),
    .full_i       ({wb_if.full, sw_if.full, rd_if.full}),
    .empty_i      ({wb_if.empty, sw_if.empty, rd_if.empty}),
    .pop_i        ({wb_if.pop, sw_if.pop, rd_if.pop}),
    .flags_i      ({from_bus_o, w_o, r_o, sw_o}),
    .aq_isempty_i (aq_isempty_o)
);

`default_nettype wire

//--- verilog/cache_aq_sys.sv
`default_nettype none
`timescale 1ns/1ps

module cache_aq_sys (
    input  wire logic                          clk,
    input  wire logic                          rst_n_i,

    input  wire logic                          rd_write_i,
    input  wire logic                          sw_write_i,
    input  wire logic                          wb_write_i,
    input  wire logic                          rdsw_clr_i,
    input  wire logic                          wb_clr_i,
    input  wire logic                          read_i,
    input  wire logic                          bus_isempty_i,

    input  wire logic                          rd_valid_e_i,
    input  wire logic                          rd_valid_o_i,
    input  wire logic [aq_cfg_pkg::PADDR_W-1:0] rd_paddr_e_i,
    input  wire logic [aq_cfg_pkg::PADDR_W-1:0] rd_paddr_o_i,
    input  wire logic [aq_cfg_pkg::SIZE_W-1:0]  rd_size_e_i,
    input  wire logic [aq_cfg_pkg::SIZE_W-1:0]  rd_size_o_i,
    input  wire logic [aq_cfg_pkg::PTCID_W-1:0] rd_ptcid_i,
    input  wire logic [aq_cfg_pkg::QSLOT_W-1:0] rd_qslot_i,
    input  wire logic                          rd_pcd_i,

    input  wire logic                          sw_valid_e_i,
    input  wire logic                          sw_valid_o_i,
    input  wire logic [aq_cfg_pkg::PADDR_W-1:0] sw_paddr_e_i,
    input  wire logic [aq_cfg_pkg::PADDR_W-1:0] sw_paddr_o_i,
    input  wire logic [aq_cfg_pkg::SIZE_W-1:0]  sw_size_e_i,
    input  wire logic [aq_cfg_pkg::SIZE_W-1:0]  sw_size_o_i,
    input  wire logic [aq_cfg_pkg::PTCID_W-1:0] sw_ptcid_i,
    input  wire logic [aq_cfg_pkg::QSLOT_W-1:0] sw_qslot_i,
    input  wire logic                          sw_pcd_i,

    input  wire logic                          wb_valid_e_i,
    input  wire logic                          wb_valid_o_i,
    input  wire logic [aq_cfg_pkg::PADDR_W-1:0] wb_paddr_e_i,
    input  wire logic [aq_cfg_pkg::PADDR_W-1:0] wb_paddr_o_i,
    input  wire logic [aq_cfg_pkg::LINE_W-1:0]  wb_data_e_i,
    input  wire logic [aq_cfg_pkg::LINE_W-1:0]  wb_data_o_i,
    input  wire logic [aq_cfg_pkg::MASK_W-1:0]  wb_mask_e_i,
    input  wire logic [aq_cfg_pkg::MASK_W-1:0]  wb_mask_o_i,
    input  wire logic [aq_cfg_pkg::SIZE_W-1:0]  wb_size_e_i,
    input  wire logic [aq_cfg_pkg::SIZE_W-1:0]  wb_size_o_i,
    input  wire logic [aq_cfg_pkg::PTCID_W-1:0] wb_ptcid_i,
    input  wire logic                          wb_pcd_i,

    input  wire logic                          bus_valid_e_i,
    input  wire logic                          bus_valid_o_i,
    input  wire logic [aq_cfg_pkg::PADDR_W-1:0] bus_paddr_e_i,
    input  wire logic [aq_cfg_pkg::PADDR_W-1:0] bus_paddr_o_i,
    input  wire logic [aq_cfg_pkg::LINE_W-1:0]  bus_data_e_i,
    input  wire logic [aq_cfg_pkg::LINE_W-1:0]  bus_data_o_i,
    input  wire logic                          bus_pcd_i,

    output logic                               valid_e_o,
    output logic                               valid_o_o,
    output logic [aq_cfg_pkg::PADDR_W-1:0]      paddr_e_o,
    output logic [aq_cfg_pkg::PADDR_W-1:0]      paddr_o_o,
    output logic [aq_cfg_pkg::LINE_W-1:0]       data_e_o,
    output logic [aq_cfg_pkg::LINE_W-1:0]       data_o_o,
    output logic [aq_cfg_pkg::MASK_W-1:0]       mask_e_o,
    output logic [aq_cfg_pkg::MASK_W-1:0]       mask_o_o,
    output logic [aq_cfg_pkg::SIZE_W-1:0]       size_e_o,
    output logic [aq_cfg_pkg::SIZE_W-1:0]       size_o_o,
    output logic [aq_cfg_pkg::PTCID_W-1:0]      ptcid_o,
    output logic [aq_cfg_pkg::QSLOT_W-1:0]      qslot_o,
    output logic                               pcd_o,

    output logic                               from_bus_o,
    output logic                               w_o,
    output logic                               sw_o,
    output logic                               r_o,
    output logic                               aq_isempty_o,
    output logic                               rdaq_isfull_o,
    output logic                               swaq_isfull_o,
    output logic                               wbaq_isfull_o
);

    import aq_req_pkg::*;

    rdsw_req_t rd_req;
    rdsw_req_t sw_req;
    wb_req_t   wb_req;
    aq_out_t   bus_req;
    aq_out_t   sel_out;

    aq_if #(.payload_t(rdsw_req_t)) rd_if ();
    aq_if #(.payload_t(rdsw_req_t)) sw_if ();
    aq_if #(.payload_t(wb_req_t))   wb_if ();

    assign rd_req = '{valid_e: rd_valid_e_i, valid_o: rd_valid_o_i,
                      paddr_e: rd_paddr_e_i, paddr_o: rd_paddr_o_i,
                      size_e: rd_size_e_i, size_o: rd_size_o_i,
                      ptcid: rd_ptcid_i, qslot: rd_qslot_i, pcd: rd_pcd_i};

    assign sw_req = '{valid_e: sw_valid_e_i, valid_o: sw_valid_o_i,
                      paddr_e: sw_paddr_e_i, paddr_o: sw_paddr_o_i,
                      size_e: sw_size_e_i, size_o: sw_size_o_i,
                      ptcid: sw_ptcid_i, qslot: sw_qslot_i, pcd: sw_pcd_i};

    assign wb_req = '{valid_e: wb_valid_e_i, valid_o: wb_valid_o_i,
                      paddr_e: wb_paddr_e_i, paddr_o: wb_paddr_o_i,
                      data_e: wb_data_e_i, data_o: wb_data_o_i,
                      mask_e: wb_mask_e_i, mask_o: wb_mask_o_i,
                      size_e: wb_size_e_i, size_o: wb_size_o_i,
                      ptcid: wb_ptcid_i, pcd: wb_pcd_i};

    // fills write the whole line
    assign bus_req = '{valid_e: bus_valid_e_i, valid_o: bus_valid_o_i,
                       paddr_e: bus_paddr_e_i, paddr_o: bus_paddr_o_i,
                       data_e: bus_data_e_i, data_o: bus_data_o_i,
                       mask_e: '1, mask_o: '1,
                       size_e: '0, size_o: '0,
                       ptcid: '0, qslot: '0, pcd: bus_pcd_i};

    access_queue #(.payload_t(rdsw_req_t)) rdaq (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (rdsw_clr_i),
        .write_i (rd_write_i),
        .din_i   (rd_req),
        .port_o  (rd_if.queue)
    );

    access_queue #(.payload_t(rdsw_req_t)) swaq (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (rdsw_clr_i),
        .write_i (sw_write_i),
        .din_i   (sw_req),
        .port_o  (sw_if.queue)
    );

    access_queue #(.payload_t(wb_req_t)) wbaq (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (wb_clr_i),
        .write_i (wb_write_i),
        .din_i   (wb_req),
        .port_o  (wb_if.queue)
    );

    aq_selector u_sel (
        .rd_q_i        (rd_if.sel),
        .sw_q_i        (sw_if.sel),
        .wb_q_i        (wb_if.sel),
        .bus_isempty_i (bus_isempty_i),
        .bus_req_i     (bus_req),
        .read_i        (read_i),
        .out_o         (sel_out),
        .from_bus_o    (from_bus_o),
        .w_o           (w_o),
        .r_o           (r_o),
        .sw_o          (sw_o),
        .aq_isempty_o  (aq_isempty_o)
    );

    assign rdaq_isfull_o = rd_if.full;
    assign swaq_isfull_o = sw_if.full;
    assign wbaq_isfull_o = wb_if.full;

    assign valid_e_o = sel_out.valid_e;
    assign valid_o_o = sel_out.valid_o;
    assign paddr_e_o = sel_out.paddr_e;
    assign paddr_o_o = sel_out.paddr_o;
    assign data_e_o  = sel_out.data_e;
    assign data_o_o  = sel_out.data_o;
    assign mask_e_o  = sel_out.mask_e;
    assign mask_o_o  = sel_out.mask_o;
    assign size_e_o  = sel_out.size_e;
    assign size_o_o  = sel_out.size_o;
    assign ptcid_o   = sel_out.ptcid;
    assign qslot_o   = sel_out.qslot;
    assign pcd_o     = sel_out.pcd;

endmodule

`default_nettype wire

//--- verilog/aq_selector.sv
`default_nettype none
`timescale 1ns/1ps

module aq_selector (
    aq_if.sel                        rd_q_i,
    aq_if.sel                        sw_q_i,
    aq_if.sel                        wb_q_i,
    input  wire logic                bus_isempty_i,
    input  wire aq_req_pkg::aq_out_t bus_req_i,
    input  wire logic                read_i,
    output aq_req_pkg::aq_out_t      out_o,
    output logic                     from_bus_o,
    output logic                     w_o,
    output logic                     r_o,
    output logic                     sw_o,
    output logic                     aq_isempty_o
);

    import aq_req_pkg::*;

    aq_src_e src;

    // loads and stores carry no data, so data and mask stay zero
    function automatic aq_out_t widen_rdsw(input rdsw_req_t req);
        aq_out_t res;
        res         = '0;
        res.valid_e = req.valid_e;
        res.valid_o = req.valid_o;
        res.paddr_e = req.paddr_e;
        res.paddr_o = req.paddr_o;
        res.size_e  = req.size_e;
        res.size_o  = req.size_o;
        res.ptcid   = req.ptcid;
        res.qslot   = req.qslot;
        res.pcd     = req.pcd;
        return res;
    endfunction

    // writebacks have no qslot
    function automatic aq_out_t widen_wb(input wb_req_t req);
        aq_out_t res;
        res         = '0;
        res.valid_e = req.valid_e;
        res.valid_o = req.valid_o;
        res.paddr_e = req.paddr_e;
        res.paddr_o = req.paddr_o;
        res.data_e  = req.data_e;
        res.data_o  = req.data_o;
        res.mask_e  = req.mask_e;
        res.mask_o  = req.mask_o;
        res.size_e  = req.size_e;
        res.size_o  = req.size_o;
        res.ptcid   = req.ptcid;
        res.pcd     = req.pcd;
        return res;
    endfunction

    // bus > wb > rd > sw
    always_comb begin
        if (!bus_isempty_i) begin
            src = SRC_BUS;
        end else if (!wb_q_i.empty) begin
            src = SRC_WB;
        end else if (!rd_q_i.empty) begin
            src = SRC_RD;
        end else if (!sw_q_i.empty) begin
            src = SRC_SW;
        end else begin
            src = SRC_NONE;
        end
    end

    always_comb begin
        case (src)
            SRC_BUS: out_o = bus_req_i;
            SRC_WB:  out_o = widen_wb(wb_q_i.head);
            SRC_RD:  out_o = widen_rdsw(rd_q_i.head);
            SRC_SW:  out_o = widen_rdsw(sw_q_i.head);
            default: out_o = '0;
        endcase
    end

    assign from_bus_o = (src == SRC_BUS);
    assign w_o        = (src == SRC_WB);
    assign r_o        = (src == SRC_RD);
    assign sw_o       = (src == SRC_SW);

    // bus fill queue is popped by the consumer itself
    assign wb_q_i.pop = read_i && (src == SRC_WB);
    assign rd_q_i.pop = read_i && (src == SRC_RD);
    assign sw_q_i.pop = read_i && (src == SRC_SW);

    assign aq_isempty_o = bus_isempty_i && wb_q_i.empty && rd_q_i.empty && sw_q_i.empty;

endmodule

`default_nettype wire

//--- verilog/access_queue.sv
`default_nettype none
`timescale 1ns/1ps

module access_queue #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    input  wire logic     clr_i,
    input  wire logic     write_i,
    input  wire payload_t din_i,
    aq_if.queue           port_o
);

    import aq_cfg_pkg::*;

    payload_t mem [AQ_DEPTH];

    logic [AQ_PTR_W-1:0] wr_ptr;
    logic [AQ_PTR_W-1:0] rd_ptr;
    logic [AQ_CNT_W-1:0] count;
    logic                full;
    logic                empty;
    logic                push;
    logic                pop;

    // wraps at any depth, not only powers of two
    function automatic logic [AQ_PTR_W-1:0] next_ptr(input logic [AQ_PTR_W-1:0] ptr);
        if (ptr == AQ_PTR_W'(AQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == AQ_CNT_W'(AQ_DEPTH));
    assign empty = (count == '0);
    assign pop   = port_o.pop;

    // a pop frees a slot in the same cycle
    assign push = write_i && (!full || pop);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    assign port_o.head  = mem[rd_ptr];
    assign port_o.empty = empty;
    assign port_o.full  = full;

endmodule

`default_nettype wire

//--- verilog/aq_if.sv
`default_nettype none
`timescale 1ns/1ps

interface aq_if #(
    parameter type payload_t = logic
) ();

    // oldest entry, valid only while empty is low
    payload_t head;
    logic     empty;
    logic     full;
    // from the selector, only for the chosen source
    logic     pop;

    modport queue (
        output head,
        output empty,
        output full,
        input  pop
    );

    modport sel (
        input  head,
        input  empty,
        input  full,
        output pop
    );

endinterface

`default_nettype wire

//--- verilog/aq_req_pkg.sv
`default_nettype none

package aq_req_pkg;

    import aq_cfg_pkg::*;

    // load or store, no payload data
    typedef struct packed {
        logic               valid_e;
        logic               valid_o;
        logic [PADDR_W-1:0] paddr_e;
        logic [PADDR_W-1:0] paddr_o;
        logic [SIZE_W-1:0]  size_e;
        logic [SIZE_W-1:0]  size_o;
        logic [PTCID_W-1:0] ptcid;
        logic [QSLOT_W-1:0] qslot;
        logic               pcd;
    } rdsw_req_t;

    // dirty line eviction
    typedef struct packed {
        logic               valid_e;
        logic               valid_o;
        logic [PADDR_W-1:0] paddr_e;
        logic [PADDR_W-1:0] paddr_o;
        logic [LINE_W-1:0]  data_e;
        logic [LINE_W-1:0]  data_o;
        logic [MASK_W-1:0]  mask_e;
        logic [MASK_W-1:0]  mask_o;
        logic [SIZE_W-1:0]  size_e;
        logic [SIZE_W-1:0]  size_o;
        logic [PTCID_W-1:0] ptcid;
        logic               pcd;
    } wb_req_t;

    // what the consumer sees, whatever the source
    typedef struct packed {
        logic               valid_e;
        logic               valid_o;
        logic [PADDR_W-1:0] paddr_e;
        logic [PADDR_W-1:0] paddr_o;
        logic [LINE_W-1:0]  data_e;
        logic [LINE_W-1:0]  data_o;
        logic [MASK_W-1:0]  mask_e;
        logic [MASK_W-1:0]  mask_o;
        logic [SIZE_W-1:0]  size_e;
        logic [SIZE_W-1:0]  size_o;
        logic [PTCID_W-1:0] ptcid;
        logic [QSLOT_W-1:0] qslot;
        logic               pcd;
    } aq_out_t;

    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_BUS,
        SRC_WB,
        SRC_RD,
        SRC_SW
    } aq_src_e;

endpackage

`default_nettype wire

//--- verilog/aq_cfg_pkg.sv
`default_nettype none

package aq_cfg_pkg;

    // per-bank request fields
    localparam int PADDR_W = 15;
    localparam int LINE_W  = 128;
    localparam int MASK_W  = LINE_W / 8;
    localparam int SIZE_W  = 2;

    // request tags
    localparam int PTCID_W = 7;
    localparam int QSLOT_W = 8;

    // queue sizing
    localparam int AQ_DEPTH = 8;
    localparam int AQ_PTR_W = (AQ_DEPTH > 1) ? $clog2(AQ_DEPTH) : 1;
    // one extra state so a full queue is distinct from an empty one
    localparam int AQ_CNT_W = $clog2(AQ_DEPTH + 1);

endpackage

`default_nettype wire
